/* Bender.yml */
package:
  name: pkt_buffer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/buf_payload_pkg.sv
      - src/buf_status_pkg.sv
      - src/sfifof.sv
      - src/sfifof_fo.sv
      - src/frame_packer.sv
      - src/frame_unpacker.sv
      - src/pkt_buffer.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/pkt_buffer_tb.sv

/* dv/pkt_buffer_tb.sv */
// testbench top with frame table, reference byte and length queues, lcg, output monitor and watchdog
`include "pkt_buffer_settings.svh"

module pkt_buffer_tb;

	localparam int NROWS = 12;
	localparam int NDIRECT = 6;

	// one row per frame
	// hold = cycles of out_take low at the row start
	// ovf = strobes made while in_room is low
	// drain = wait for the frame to leave before the next row
	// fill = in_room must fall during the hold
	typedef struct packed {
		logic [7:0] len;
		logic [7:0] hold;
		logic [3:0] ovf;
		logic       drain;
		logic       fill;
	} row_t;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic [7:0] in_byte;
	logic in_last;
	logic in_room;
	logic out_take;
	logic out_start;
	logic [`BUF_LEN_BITS-1:0] out_len;
	logic out_valid;
	logic [7:0] out_byte;
	logic out_last;
	buf_status_pkg::data_level_t data_level;
	buf_status_pkg::ovf_count_t overflow_count;

	row_t rows [NROWS];
	logic [7:0] ref_bytes [$];
	int ref_lens [$];
	logic [31:0] lcg_state = 32'd12;
	int errors = 0;
	int frames_done = 0;
	int bytes_seen = 0;
	int hold_left = 0;
	int ovf_expected = 0;
	int cycle_limit = 0;
	int cur_len = 0;
	int cur_remain = 0;
	int frame_err_base = 0;
	bit prev_start = 1'b0;

	pkt_buffer dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.in_valid       (in_valid),
		.in_byte        (in_byte),
		.in_last        (in_last),
		.in_room        (in_room),
		.out_take       (out_take),
		.out_start      (out_start),
		.out_len        (out_len),
		.out_valid      (out_valid),
		.out_byte       (out_byte),
		.out_last       (out_last),
		.data_level     (data_level),
		.overflow_count (overflow_count)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ============================================================
	// helpers
	// ============================================================

	// lcg step returning bits from the upper half of the state
	function automatic int unsigned lcg_next(input int unsigned range);
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return (lcg_state >> 16) % range;
	endfunction

	function automatic row_t make_row(input int len, input int hold, input int ovf,
		input bit drain, input bit fill);
		row_t r;
		r.len = 8'(len);
		r.hold = 8'(hold);
		r.ovf = 4'(ovf);
		r.drain = drain;
		r.fill = fill;
		return r;
	endfunction

	task automatic flag_error(input string msg);
		$display("[FAIL] t=%0t: %s", $time, msg);
		errors++;
	endtask

	// falling edge clears the strobe and sets take from the hold counter
	task automatic next_cycle();
		@(negedge clk);
		in_valid = 1'b0;
		in_last = 1'b0;
		if (hold_left > 0) begin
			out_take = 1'b0;
			hold_left--;
		end else begin
			out_take = 1'b1;
		end
	endtask

	// one frame from a table row
	task automatic send_frame(input row_t r);
		int sent;
		int junk_left;
		bit saw_low;
		logic [7:0] b;
		sent = 0;
		junk_left = r.ovf;
		saw_low = 1'b0;
		hold_left = r.hold;
		while (sent < r.len) begin
			next_cycle();
			if (in_room) begin
				b = 8'(lcg_next(256));
				in_valid = 1'b1;
				in_byte = b;
				in_last = (sent == int'(r.len) - 1);
				ref_bytes.push_back(b);
				sent++;
				if (in_last) begin
					ref_lens.push_back(r.len);
				end
			end else begin
				// first stall inside the frame with take low means the fifo holds depth minus one
				if (!saw_low && r.fill && sent > 0 && !out_take) begin
					saw_low = 1'b1;
					if (data_level != `BUF_DATA_DEPTH - 1) begin
						flag_error($sformatf("in_room low at data_level %0d", data_level));
					end
				end
				// ignored strobe with in_last on the last one
				if (junk_left > 0) begin
					in_valid = 1'b1;
					in_byte = 8'hee;
					in_last = (junk_left == 1);
					junk_left--;
					ovf_expected++;
				end
			end
		end
		if (r.fill && !saw_low) begin
			$display("error: in_room never fell while out_take was held low");
			errors++;
		end
		if (junk_left != 0) begin
			$display("error: %0d overflow strobes were never made", junk_left);
			errors++;
		end
	endtask

	// ============================================================
	// output monitor
	// ============================================================

	always @(posedge clk) begin : monitor
		logic [7:0] exp_byte;
		if (rst_n) begin
			if (prev_start && out_take && !out_valid) begin
				flag_error("no byte in the cycle after out_start");
			end
			if (out_valid && !out_take) begin
				flag_error("out_valid while out_take is low");
			end
			if (out_last && !out_valid) begin
				flag_error("out_last without out_valid");
			end
			if (out_start) begin
				if (ref_lens.size() == 0) begin
					flag_error("out_start with no frame pending");
				end else begin
					cur_len = ref_lens.pop_front();
					cur_remain = cur_len;
					frame_err_base = errors;
					if (out_len != cur_len) begin
						flag_error($sformatf("out_len %0d, expected %0d", out_len, cur_len));
					end
				end
			end
			if (out_valid) begin
				if (cur_remain == 0 || ref_bytes.size() == 0) begin
					flag_error("byte outside a frame");
				end else begin
					exp_byte = ref_bytes.pop_front();
					if (out_byte != exp_byte) begin
						flag_error($sformatf("out_byte %h, expected %h", out_byte, exp_byte));
					end
					if (out_last != (cur_remain == 1)) begin
						flag_error($sformatf("out_last %0b with %0d bytes left", out_last,
							cur_remain));
					end
					cur_remain--;
					bytes_seen++;
					if (cur_remain == 0) begin
						$display("frame %0d len %0d: %s", frames_done, cur_len,
							(errors == frame_err_base) ? "ok" : "mismatch");
						frames_done++;
					end
				end
			end
			prev_start = out_start;
		end
	end

	// cycle counter armed once the table is built
	initial begin : watchdog
		int cycles;
		cycles = 0;
		wait (cycle_limit != 0);
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: frames still missing after %0d cycles", cycle_limit);
		$display(">>> FAIL");
		$finish;
	end

	// ============================================================
	// stimulus
	// ============================================================

	initial begin : main
		int i;
		int sum_len;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_byte = 8'h00;
		in_last = 1'b0;
		out_take = 1'b0;

		// even lengths, single byte and odd length
		rows[0] = make_row(6, 0, 0, 1, 0);
		rows[1] = make_row(10, 3, 0, 1, 0);
		rows[2] = make_row(1, 0, 0, 1, 0);
		rows[3] = make_row(7, 0, 0, 1, 0);
		// whole frame parked under take low
		rows[4] = make_row(8, 10, 0, 0, 0);
		// next frame fills the fifo behind it and strobes past in_room
		rows[5] = make_row(10, 30, 3, 1, 1);
		// back to back frames of random length and hold
		// no longer than the data fifo can hold whole
		for (i = NDIRECT; i < NROWS; i++) begin
			rows[i] = make_row(1 + lcg_next(2 * (`BUF_DATA_DEPTH - 1)), lcg_next(12), 0, 0, 0);
		end
		sum_len = 0;
		for (i = 0; i < NROWS; i++) begin
			sum_len += rows[i].len;
		end
		cycle_limit = 4 * sum_len + 200;

		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		next_cycle();
		if (in_room !== 1'b1 || out_valid !== 1'b0 || out_start !== 1'b0) begin
			flag_error("control outputs wrong after reset");
		end
		if (data_level !== '0 || overflow_count !== '0) begin
			flag_error("data_level or overflow_count not 0 after reset");
		end
		$display("reset values: %s", (errors == 0) ? "ok" : "mismatch");

		for (i = 0; i < NROWS; i++) begin
			send_frame(rows[i]);
			if (rows[i].drain) begin
				while (frames_done < i + 1) begin
					next_cycle();
				end
				if (data_level != 0) begin
					flag_error($sformatf("data_level %0d after drain", data_level));
				end
				if (overflow_count != ovf_expected) begin
					flag_error($sformatf("overflow_count %0d, expected %0d",
						overflow_count, ovf_expected));
				end
			end
		end
		while (frames_done < NROWS) begin
			next_cycle();
		end
		next_cycle();
		if (data_level != 0 || ref_bytes.size() != 0 || ref_lens.size() != 0) begin
			flag_error("data left behind after the last frame");
		end
		if (overflow_count != ovf_expected) begin
			flag_error($sformatf("overflow_count %0d, expected %0d", overflow_count,
				ovf_expected));
		end

		$display("done: %0d frames, %0d bytes, %0d errors", frames_done, bytes_seen, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* include/pkt_buffer_settings.svh */
// build-time sizes: word bytes, fifo depths with count widths, frame length width
`ifndef PKT_BUFFER_SETTINGS_SVH
`define PKT_BUFFER_SETTINGS_SVH

// ============================================================
// data path
// ============================================================

// bytes packed into one fifo word
`define BUF_WORD_BYTES 2

// data fifo capacity in words, output register included
`define BUF_DATA_DEPTH 8
// wide enough to hold BUF_DATA_DEPTH itself
`define BUF_DATA_DEPTH_BITS 4

// ============================================================
// descriptor path
// ============================================================

// frames that can be queued at once
`define BUF_DESC_DEPTH 4
`define BUF_DESC_DEPTH_BITS 3

// frame length in bytes, max frame is 2**BUF_LEN_BITS - 1
`define BUF_LEN_BITS 8

`endif

/* pkt_buffer.f */
+incdir+include
src/buf_payload_pkg.sv
src/buf_status_pkg.sv
src/sfifof.sv
src/sfifof_fo.sv
src/frame_packer.sv
src/frame_unpacker.sv
src/pkt_buffer.sv
dv/pkt_buffer_tb.sv

/* src/buf_payload_pkg.sv */
// payload types: data word and frame descriptor
`include "pkt_buffer_settings.svh"

package buf_payload_pkg;

	// ============================================================
	// data fifo payload
	// ============================================================

	// byte 0 is the earlier byte of the stream
	// cnt_m1 = valid bytes minus one
	// 0 means only byte 0 holds data (odd tail of a frame)
	typedef struct packed {
		logic [`BUF_WORD_BYTES-1:0][7:0] bytes;
		logic                            cnt_m1;
	} data_word_t;

	// ============================================================
	// descriptor fifo payload
	// ============================================================

	// one per frame, written with the last word
	// len counts accepted bytes only
	typedef struct packed {
		logic [`BUF_LEN_BITS-1:0] len;
	} frame_desc_t;

endpackage

/* src/buf_status_pkg.sv */
// status types: data fifo fill level and overflow counter
`include "pkt_buffer_settings.svh"

package buf_status_pkg;

	// data fifo word count, 0 up to BUF_DATA_DEPTH
	typedef logic [`BUF_DATA_DEPTH_BITS-1:0] data_level_t;

	// bytes dropped while in_room was low
	// saturates at 255, cleared only by reset
	typedef logic [7:0] ovf_count_t;

endpackage

/* src/frame_packer.sv */
// module frame_packer: byte to word packing, descriptor write, room level, overflow count
`include "pkt_buffer_settings.svh"

module frame_packer (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         in_valid,
	input  logic [7:0]                   in_byte,
	input  logic                         in_last,
	input  logic                         data_fullm1,
	input  logic                         data_full,
	input  logic                         desc_full,
	output logic                         in_room,
	output logic                         word_wr,
	output buf_payload_pkg::data_word_t  word_data,
	output logic                         desc_wr,
	output buf_payload_pkg::frame_desc_t desc_data,
	output buf_status_pkg::ovf_count_t   overflow_count
);

	logic accept;
	logic dropped;
	logic word_done;
	logic half_pending;
	logic [7:0] half_byte;
	logic [`BUF_LEN_BITS-1:0] frame_len;

	// ============================================================
	// acceptance
	// ============================================================

	// fifo flags lag the registered pushes by a cycle
	// data side: fullm1 leaves room for the word still in flight
	// desc side: only full is visible, so hold off while a desc write is in flight
	assign in_room = ~(data_fullm1 | desc_full | desc_wr | (half_pending & data_full));

	assign accept = in_valid & in_room;
	assign dropped = in_valid & ~in_room;

	// pair complete, or frame ends on a half word
	assign word_done = accept & (half_pending | in_last);

	// ============================================================
	// control state
	// ============================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			half_pending   <= 1'b0;
			frame_len      <= '0;
			word_wr        <= 1'b0;
			desc_wr        <= 1'b0;
			overflow_count <= '0;
		end else begin
			word_wr <= word_done;
			desc_wr <= accept & in_last;
			if (accept) begin
				// toggles per byte, forced clear at frame end
				half_pending <= ~half_pending & ~in_last;
				if (in_last) begin
					frame_len <= '0;
				end else begin
					frame_len <= frame_len + 1'b1;
				end
			end
			// dropped byte leaves the frame open, last flag included
			if (dropped && overflow_count != 8'hff) begin
				overflow_count <= overflow_count + 1'b1;
			end
		end
	end

	// ============================================================
	// payload
	// ============================================================

	always_ff @(posedge clk) begin
		if (accept & ~half_pending) begin
			half_byte <= in_byte;
		end
		if (word_done) begin
			// lone tail byte sits in byte 0
			word_data.bytes[0] <= half_pending ? half_byte : in_byte;
			word_data.bytes[1] <= in_byte;
			word_data.cnt_m1   <= half_pending;
		end
		if (accept & in_last) begin
			desc_data.len <= frame_len + 1'b1;
		end
	end

endmodule

/* src/frame_unpacker.sv */
// module frame_unpacker: descriptor pop, frame start, byte stream out under take
`include "pkt_buffer_settings.svh"

module frame_unpacker (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         desc_empty,
	input  buf_payload_pkg::frame_desc_t desc_head,
	output logic                         desc_rd,
	input  logic                         word_empty,
	input  buf_payload_pkg::data_word_t  word_head,
	output logic                         word_rd,
	input  logic                         out_take,
	output logic                         out_start,
	output logic [`BUF_LEN_BITS-1:0]     out_len,
	output logic                         out_valid,
	output logic [7:0]                   out_byte,
	output logic                         out_last
);

	typedef enum logic {
		ST_IDLE,
		ST_STREAM
	} state_t;

	state_t state;
	logic [`BUF_LEN_BITS-1:0] remain;
	logic byte_idx;
	logic take_desc;
	logic word_end;

	// ============================================================
	// byte stream, combinational on take
	// ============================================================

	// nothing during the start pulse, first byte one cycle later
	assign out_valid = (state == ST_STREAM) & ~out_start & out_take & ~word_empty;
	assign out_byte = word_head.bytes[byte_idx];
	assign out_last = out_valid & (remain == 1);

	// last valid byte of the head word
	assign word_end = (byte_idx == word_head.cnt_m1);
	// pop together with that final byte
	assign word_rd = out_valid & word_end;

	// new frame as soon as a descriptor shows while idle
	assign take_desc = (state == ST_IDLE) & ~desc_empty;

	// ============================================================
	// fsm
	// ============================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= ST_IDLE;
			desc_rd   <= 1'b0;
			out_start <= 1'b0;
			remain    <= '0;
			byte_idx  <= 1'b0;
		end else begin
			// one-cycle pulses
			desc_rd   <= 1'b0;
			out_start <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (take_desc) begin
						desc_rd   <= 1'b1;
						out_start <= 1'b1;
						remain    <= desc_head.len;
						byte_idx  <= 1'b0;
						state     <= ST_STREAM;
					end
				end
				ST_STREAM: begin
					// take low: hold position
					if (out_valid) begin
						remain   <= remain - 1'b1;
						byte_idx <= word_end ? 1'b0 : byte_idx + 1'b1;
						if (remain == 1) begin
							state <= ST_IDLE;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// length shown with the start pulse
	always_ff @(posedge clk) begin
		if (take_desc) begin
			out_len <= desc_head.len;
		end
	end

endmodule

/* src/pkt_buffer.sv */
// module pkt_buffer: packer, data and descriptor fifos, unpacker
`include "pkt_buffer_settings.svh"

module pkt_buffer (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        in_valid,
	input  logic [7:0]                  in_byte,
	input  logic                        in_last,
	output logic                        in_room,
	input  logic                        out_take,
	output logic                        out_start,
	output logic [`BUF_LEN_BITS-1:0]    out_len,
	output logic                        out_valid,
	output logic [7:0]                  out_byte,
	output logic                        out_last,
	output buf_status_pkg::data_level_t data_level,
	output buf_status_pkg::ovf_count_t  overflow_count
);

	logic word_wr;
	logic word_rd;
	logic desc_wr;
	logic desc_rd;
	buf_payload_pkg::data_word_t word_data;
	buf_payload_pkg::data_word_t word_head;
	buf_payload_pkg::frame_desc_t desc_data;
	buf_payload_pkg::frame_desc_t desc_head;
	logic data_full;
	logic data_fullm1;
	logic data_empty;
	logic desc_full;
	logic desc_empty;

	// ============================================================
	// input side
	// ============================================================

	frame_packer u_packer (
		.clk            (clk),
		.rst_n          (rst_n),
		.in_valid       (in_valid),
		.in_byte        (in_byte),
		.in_last        (in_last),
		.data_fullm1    (data_fullm1),
		.data_full      (data_full),
		.desc_full      (desc_full),
		.in_room        (in_room),
		.word_wr        (word_wr),
		.word_data      (word_data),
		.desc_wr        (desc_wr),
		.desc_data      (desc_data),
		.overflow_count (overflow_count)
	);

	// ============================================================
	// storage
	// ============================================================

	// word fifo, its count is the visible fill level
	sfifof_fo #(
		.payload_t  (buf_payload_pkg::data_word_t),
		.DEPTH_BITS (`BUF_DATA_DEPTH_BITS),
		.DEPTH      (`BUF_DATA_DEPTH)
	) u_data_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.din     (word_data),
		.wr      (word_wr),
		.rd      (word_rd),
		.count   (data_level),
		.full    (data_full),
		.empty   (data_empty),
		.fullm1  (data_fullm1),
		.emptyp2 (),
		.dout    (word_head)
	);

	// one entry per complete frame
	sfifof_fo #(
		.payload_t  (buf_payload_pkg::frame_desc_t),
		.DEPTH_BITS (`BUF_DESC_DEPTH_BITS),
		.DEPTH      (`BUF_DESC_DEPTH)
	) u_desc_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.din     (desc_data),
		.wr      (desc_wr),
		.rd      (desc_rd),
		.count   (),
		.full    (desc_full),
		.empty   (desc_empty),
		.fullm1  (),
		.emptyp2 (),
		.dout    (desc_head)
	);

	// ============================================================
	// output side
	// ============================================================

	frame_unpacker u_unpacker (
		.clk        (clk),
		.rst_n      (rst_n),
		.desc_empty (desc_empty),
		.desc_head  (desc_head),
		.desc_rd    (desc_rd),
		.word_empty (data_empty),
		.word_head  (word_head),
		.word_rd    (word_rd),
		.out_take   (out_take),
		.out_start  (out_start),
		.out_len    (out_len),
		.out_valid  (out_valid),
		.out_byte   (out_byte),
		.out_last   (out_last)
	);

endmodule

/* src/sfifof.sv */
// module sfifof: flop-array synchronous fifo with next count and near flags
module sfifof #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH_BITS = 3,
	parameter int DEPTH = 7
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  payload_t              din,
	input  logic                  wr,
	input  logic                  rd,
	output logic [DEPTH_BITS-1:0] ncount,
	output logic [DEPTH_BITS-1:0] count,
	output logic                  full,
	output logic                  empty,
	output logic                  fullm1,
	output logic                  emptyp1,
	output logic                  emptyp2,
	output payload_t              dout
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic do_wr;
	logic do_rd;

	// pointer step with wrap, depth need not be a power of two
	function automatic logic [PTR_BITS-1:0] ptr_next(input logic [PTR_BITS-1:0] p);
		if (p == PTR_BITS'(DEPTH - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	// read from empty is dropped
	assign do_rd = rd & ~empty;
	// write into full only allowed together with a read
	assign do_wr = wr & (~full | rd);

	// ============================================================
	// next count
	// ============================================================

	always_comb begin
		case ({do_wr, do_rd})
			2'b10:   ncount = count + 1'b1;
			2'b01:   ncount = count - 1'b1;
			default: ncount = count;
		endcase
	end

	// count and all flags registered from ncount
	// so they move 1 cycle after wr or rd
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count   <= '0;
			full    <= 1'b0;
			empty   <= 1'b1;
			fullm1  <= (DEPTH <= 1);
			emptyp1 <= 1'b1;
			emptyp2 <= 1'b1;
		end else begin
			count   <= ncount;
			full    <= (ncount == DEPTH);
			empty   <= (ncount == 0);
			fullm1  <= (ncount >= DEPTH - 1);
			emptyp1 <= (ncount <= 1);
			emptyp2 <= (ncount <= 2);
		end
	end

	// ============================================================
	// storage
	// ============================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (do_rd) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
	end

	// head straight out of the array
	assign dout = mem[rd_ptr];

endmodule

/* src/sfifof_fo.sv */
// module sfifof_fo: fifo with a registered head word in front of sfifof
module sfifof_fo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH_BITS = 3,
	parameter int DEPTH = 7
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  payload_t              din,
	input  logic                  wr,
	input  logic                  rd,
	output logic [DEPTH_BITS-1:0] count,
	output logic                  full,
	output logic                  empty,
	output logic                  fullm1,
	output logic                  emptyp2,
	output payload_t              dout
);

	logic ff_full;
	logic ff_empty;
	logic ff_fullm1;
	logic ff_emptyp1;
	logic [DEPTH_BITS-1:0] ff_ncount;
	payload_t ff_dout;
	logic ff_rd;
	logic ff_wr;
	logic nempty;
	logic [DEPTH_BITS-1:0] ncount;

	// ============================================================
	// head register control
	// ============================================================

	// head goes empty only on a lone read with nothing behind it
	assign nempty = (wr == rd) ? empty : (rd & ff_empty);

	// total = inner entries + occupied head
	assign ncount = ff_ncount + {{(DEPTH_BITS - 1){1'b0}}, ~nempty};

	// refill head from the inner fifo when it has data
	assign ff_rd = rd & ~ff_empty;
	// inner fifo skipped when din can go straight to the head
	assign ff_wr = wr & ~(empty | (ff_empty & rd));

	// head full implies the inner fifo decides full/near full
	assign full = ff_full;
	assign fullm1 = ff_fullm1;
	// head + at most one inner entry
	assign emptyp2 = ff_emptyp1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			empty <= 1'b1;
			count <= '0;
		end else begin
			empty <= nempty;
			count <= ncount;
		end
	end

	// head load on write into empty or on any pop
	always_ff @(posedge clk) begin
		if ((wr & empty) | rd) begin
			dout <= ff_rd ? ff_dout : din;
		end
	end

	// ============================================================
	// inner fifo, one entry smaller
	// ============================================================

	sfifof #(
		.payload_t  (payload_t),
		.DEPTH_BITS (DEPTH_BITS),
		.DEPTH      (DEPTH - 1)
	) u_sfifof (
		.clk     (clk),
		.rst_n   (rst_n),
		.din     (din),
		.wr      (ff_wr),
		.rd      (ff_rd),
		.ncount  (ff_ncount),
		.count   (),
		.full    (ff_full),
		.empty   (ff_empty),
		.fullm1  (ff_fullm1),
		.emptyp1 (ff_emptyp1),
		.emptyp2 (),
		.dout    (ff_dout)
	);

endmodule
